// File: common/pipe_pkg.sv
// shared types for the toy cpu; pc fields are 16 bits wide, so PC_W must not exceed 16
package pipe_pkg;

    ////////////////////
    // scalar types
    ////////////////////
    typedef logic [1:0]  reg_idx_t;
    typedef logic [7:0]  word_t;
    typedef logic [15:0] cyc_t;
    typedef logic [7:0]  tag_t;
    // widest pc any stage or record carries
    typedef logic [15:0] pc_t;
    // decode hold cycles of one instruction
    typedef logic [3:0]  stall_cnt_t;

    // codes 5 to 15 are undefined and decode as no-op
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_addi = 4'd3,
        op_halt = 4'd4
    } opcode_e;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_drain,
        st_halted
    } ctrl_state_e;

    // rt lives in imm[7:6]
    typedef struct packed {
        logic [3:0] opcode;
        reg_idx_t   rd;
        reg_idx_t   rs;
        word_t      imm;
    } instr_t;

    ////////////////////
    // stage registers
    ////////////////////
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        instr_t instr;
    } fd_stage_t;

    // operand b already holds the immediate for addi
    typedef struct packed {
        logic     valid;
        pc_t      pc;
        opcode_e  op;
        reg_idx_t rd;
        logic     wr;
        word_t    a;
        word_t    b;
    } de_stage_t;

    // shared by execute/memory and memory/write-back
    typedef struct packed {
        logic     valid;
        pc_t      pc;
        opcode_e  op;
        reg_idx_t rd;
        logic     wr;
        word_t    result;
    } res_stage_t;

    // tracker shadow of one stage
    typedef struct packed {
        logic       valid;
        tag_t       tag;
        cyc_t       fetch_cyc;
        stall_cnt_t stalls;
    } trk_stage_t;

    typedef struct packed {
        logic     dec_valid;
        opcode_e  dec_op;
        reg_idx_t dec_rs;
        reg_idx_t dec_rt;
        logic     ex_valid;
        logic     ex_wr;
        reg_idx_t ex_rd;
        logic     mem_valid;
        logic     mem_wr;
        reg_idx_t mem_rd;
        logic     wb_halt;
    } hazard_view_t;

    typedef struct packed {
        tag_t       tag;
        pc_t        pc;
        opcode_e    op;
        reg_idx_t   rd;
        word_t      result;
        logic       wr;
        cyc_t       fetch_cyc;
        cyc_t       wb_cyc;
        stall_cnt_t stalls;
    } retire_rec_t;

endpackage

// File: core/pipe_ctrl.sv
// run control and decode hazard check; no forwarding, so any raw hit in ex or mem stalls
`timescale 1ns/1ps

module pipe_ctrl import pipe_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  hazard_view_t hview,
    output logic         fetch_en,
    output logic         stall,
    output logic         halted
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        dec_halt;
    logic        uses_rs;
    logic        uses_rt;
    logic        rs_hit;
    logic        rt_hit;

    // source matches a valid writer in execute or memory
    function automatic logic dest_hit(hazard_view_t hv, reg_idx_t src);
        logic ex_hit;
        logic mem_hit;
        ex_hit  = hv.ex_valid && hv.ex_wr && (hv.ex_rd == src);
        mem_hit = hv.mem_valid && hv.mem_wr && (hv.mem_rd == src);
        return ex_hit || mem_hit;
    endfunction

    ////////////////////
    // hazard detection
    ////////////////////
    assign dec_halt = hview.dec_valid && (hview.dec_op == op_halt);
    // nop and halt read nothing and never stall
    assign uses_rs  = hview.dec_op inside {op_add, op_sub, op_addi};
    assign uses_rt  = hview.dec_op inside {op_add, op_sub};
    assign rs_hit   = uses_rs && dest_hit(hview, hview.dec_rs);
    assign rt_hit   = uses_rt && dest_hit(hview, hview.dec_rt);
    assign stall    = hview.dec_valid && (rs_hit || rt_hit);

    // fetch stops in the very cycle a halt sits in decode
    assign fetch_en = (state_q == st_run) && !dec_halt;
    assign halted   = (state_q == st_halted);

    ////////////////////
    // state machine
    ////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle:   if (start) state_d = st_run;
            st_run:    if (dec_halt) state_d = st_drain;
            // halt retires this cycle
            st_drain:  if (hview.wb_halt) state_d = st_halted;
            default:   state_d = st_halted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: core/reg_file.sv
// four 8-bit registers, two read ports, one write port with write-first bypass
`timescale 1ns/1ps

module reg_file import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t rd_idx_a,
    input  reg_idx_t rd_idx_b,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data,
    output word_t    rd_data_a,
    output word_t    rd_data_b
);

    word_t regs_q [4];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en) begin
            regs_q[wr_idx] <= wr_data;
        end
    end

    // same-cycle write is seen by the read, so write-back never hazards
    assign rd_data_a = (wr_en && (wr_idx == rd_idx_a)) ? wr_data : regs_q[rd_idx_a];
    assign rd_data_b = (wr_en && (wr_idx == rd_idx_b)) ? wr_data : regs_q[rd_idx_b];

endmodule

// File: core/pipe_datapath.sv
// five-stage datapath; memory stage is a pass-through and PC_W must be 16 or less
`timescale 1ns/1ps

module pipe_datapath import pipe_pkg::*; #(
    parameter int PC_W = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_en,
    input  logic            stall,
    input  logic            start,
    input  instr_t          imem_data,
    input  word_t           rf_rd_data_a,
    input  word_t           rf_rd_data_b,
    output logic [PC_W-1:0] imem_addr,
    output reg_idx_t        rf_rd_idx_a,
    output reg_idx_t        rf_rd_idx_b,
    output logic            rf_wr_en,
    output reg_idx_t        rf_wr_idx,
    output word_t           rf_wr_data,
    output hazard_view_t    hview,
    output logic            wb_valid,
    output opcode_e         wb_op,
    output reg_idx_t        wb_rd,
    output word_t           wb_result,
    output logic            wb_wr,
    output logic [PC_W-1:0] wb_pc
);

    logic [PC_W-1:0] pc_q;
    fd_stage_t       fd_q;
    de_stage_t       de_q;
    de_stage_t       de_d;
    res_stage_t      em_q;
    res_stage_t      mw_q;
    opcode_e         dec_op;
    word_t           ex_result;

    function automatic opcode_e decode_op(logic [3:0] code);
        opcode_e op;
        case (code)
            4'd1:    op = op_add;
            4'd2:    op = op_sub;
            4'd3:    op = op_addi;
            4'd4:    op = op_halt;
            default: op = op_nop;
        endcase
        return op;
    endfunction

    ////////////////////
    // fetch
    ////////////////////
    assign imem_addr = pc_q;

    // start only lands while fetch is off, i.e. in idle
    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= '0;
        end else if (start && !fetch_en) begin
            pc_q <= '0;
        end else if (fetch_en && !stall) begin
            pc_q <= pc_q + PC_W'(1);
        end
    end

    // held on stall, bubble when fetch is off
    always_ff @(posedge clk) begin
        if (!stall) begin
            fd_q.valid <= fetch_en;
            fd_q.pc    <= pc_t'(pc_q);
            fd_q.instr <= imem_data;
        end
        if (rst) begin
            fd_q.valid <= 1'b0;
        end
    end

    ////////////////////
    // decode
    ////////////////////
    assign dec_op      = decode_op(fd_q.instr.opcode);
    assign rf_rd_idx_a = fd_q.instr.rs;
    assign rf_rd_idx_b = fd_q.instr.imm[7:6];

    always_comb begin
        // stalled decode sends a bubble down
        de_d.valid = fd_q.valid && !stall;
        de_d.pc    = fd_q.pc;
        de_d.op    = dec_op;
        de_d.rd    = fd_q.instr.rd;
        de_d.wr    = dec_op inside {op_add, op_sub, op_addi};
        de_d.a     = rf_rd_data_a;
        de_d.b     = (dec_op == op_addi) ? fd_q.instr.imm : rf_rd_data_b;
    end

    always_ff @(posedge clk) begin
        de_q <= de_d;
        if (rst) begin
            de_q.valid <= 1'b0;
        end
    end

    ////////////////////
    // execute and memory
    ////////////////////
    // 8-bit wraparound, immediate already zero-extended into b
    always_comb begin
        case (de_q.op)
            op_add, op_addi: ex_result = de_q.a + de_q.b;
            op_sub:          ex_result = de_q.a - de_q.b;
            default:         ex_result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        em_q.valid  <= de_q.valid;
        em_q.pc     <= de_q.pc;
        em_q.op     <= de_q.op;
        em_q.rd     <= de_q.rd;
        em_q.wr     <= de_q.wr;
        em_q.result <= ex_result;
        // no loads or stores
        mw_q        <= em_q;
        if (rst) begin
            em_q.valid <= 1'b0;
            mw_q.valid <= 1'b0;
        end
    end

    ////////////////////
    // write-back
    ////////////////////
    assign rf_wr_en   = mw_q.valid && mw_q.wr;
    assign rf_wr_idx  = mw_q.rd;
    assign rf_wr_data = mw_q.result;

    assign wb_valid  = mw_q.valid;
    assign wb_op     = mw_q.op;
    assign wb_rd     = mw_q.rd;
    assign wb_result = mw_q.result;
    assign wb_wr     = mw_q.wr;
    assign wb_pc     = mw_q.pc[PC_W-1:0];

    // view for the control
    always_comb begin
        hview.dec_valid = fd_q.valid;
        hview.dec_op    = dec_op;
        hview.dec_rs    = fd_q.instr.rs;
        hview.dec_rt    = fd_q.instr.imm[7:6];
        hview.ex_valid  = de_q.valid;
        hview.ex_wr     = de_q.wr;
        hview.ex_rd     = de_q.rd;
        hview.mem_valid = em_q.valid;
        hview.mem_wr    = em_q.wr;
        hview.mem_rd    = em_q.rd;
        hview.wb_halt   = mw_q.valid && (mw_q.op == op_halt);
    end

endmodule

// File: trace/pipe_tracker.sv
// shadow pipeline of tags and cycle stamps; cycle count and tag wrap silently at 16 and 8 bits
`timescale 1ns/1ps

module pipe_tracker import pipe_pkg::*; #(
    parameter int PC_W = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_en,
    input  logic            stall,
    input  logic            wb_valid,
    input  opcode_e         wb_op,
    input  reg_idx_t        wb_rd,
    input  word_t           wb_result,
    input  logic            wb_wr,
    input  logic [PC_W-1:0] wb_pc,
    output logic            retire,
    output retire_rec_t     retire_rec
);

    cyc_t       cyc_q;
    tag_t       tag_q;
    logic       fetch;
    trk_stage_t fd_q;
    trk_stage_t de_q;
    trk_stage_t em_q;
    trk_stage_t mw_q;

    assign fetch = fetch_en && !stall;

    ////////////////////
    // cycle count and tags
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q <= '0;
            tag_q <= '0;
        end else begin
            cyc_q <= cyc_q + 16'd1;
            if (fetch) begin
                tag_q <= tag_q + 8'd1;
            end
        end
    end

    ////////////////////
    // shadow stages
    ////////////////////
    // decode slot counts its own hold cycles
    always_ff @(posedge clk) begin
        if (stall) begin
            fd_q.stalls <= fd_q.stalls + stall_cnt_t'(1);
        end else begin
            fd_q.valid     <= fetch;
            fd_q.tag       <= tag_q;
            fd_q.fetch_cyc <= cyc_q;
            fd_q.stalls    <= '0;
        end
        if (rst) begin
            fd_q.valid <= 1'b0;
        end
    end

    // bubbles carry no tag, same as the datapath
    always_ff @(posedge clk) begin
        de_q       <= fd_q;
        de_q.valid <= fd_q.valid && !stall;
        em_q       <= de_q;
        mw_q       <= em_q;
        if (rst) begin
            de_q.valid <= 1'b0;
            em_q.valid <= 1'b0;
            mw_q.valid <= 1'b0;
        end
    end

    ////////////////////
    // retire record
    ////////////////////
    // both sides agree on the write-back slot
    assign retire = wb_valid && mw_q.valid;

    always_comb begin
        retire_rec.tag       = mw_q.tag;
        retire_rec.pc        = pc_t'(wb_pc);
        retire_rec.op        = wb_op;
        retire_rec.rd        = wb_rd;
        retire_rec.result    = wb_result;
        retire_rec.wr        = wb_wr;
        retire_rec.fetch_cyc = mw_q.fetch_cyc;
        // current count is the write-back cycle
        retire_rec.wb_cyc    = cyc_q;
        retire_rec.stalls    = mw_q.stalls;
    end

endmodule

// File: hw/toy_cpu_top.sv
// toy cpu top; program memory is outside and must answer imem_addr in the same cycle
`timescale 1ns/1ps

module toy_cpu_top import pipe_pkg::*; #(
    parameter int PC_W = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  instr_t          imem_data,
    output logic [PC_W-1:0] imem_addr,
    output logic            retire,
    output retire_rec_t     retire_rec,
    output logic            halted
);

    // control to datapath and tracker
    logic         fetch_en;
    logic         stall;
    hazard_view_t hview;

    // register file ports
    reg_idx_t rf_rd_idx_a;
    reg_idx_t rf_rd_idx_b;
    word_t    rf_rd_data_a;
    word_t    rf_rd_data_b;
    logic     rf_wr_en;
    reg_idx_t rf_wr_idx;
    word_t    rf_wr_data;

    // write-back stage for the tracker
    logic            wb_valid;
    opcode_e         wb_op;
    reg_idx_t        wb_rd;
    word_t           wb_result;
    logic            wb_wr;
    logic [PC_W-1:0] wb_pc;

    pipe_ctrl pipe_ctrl_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .hview    (hview),
        .fetch_en (fetch_en),
        .stall    (stall),
        .halted   (halted)
    );

    reg_file reg_file_inst (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_a  (rf_rd_idx_a),
        .rd_idx_b  (rf_rd_idx_b),
        .wr_en     (rf_wr_en),
        .wr_idx    (rf_wr_idx),
        .wr_data   (rf_wr_data),
        .rd_data_a (rf_rd_data_a),
        .rd_data_b (rf_rd_data_b)
    );

    pipe_datapath #(.PC_W(PC_W)) pipe_datapath_inst (
        .clk          (clk),
        .rst          (rst),
        .fetch_en     (fetch_en),
        .stall        (stall),
        .start        (start),
        .imem_data    (imem_data),
        .rf_rd_data_a (rf_rd_data_a),
        .rf_rd_data_b (rf_rd_data_b),
        .imem_addr    (imem_addr),
        .rf_rd_idx_a  (rf_rd_idx_a),
        .rf_rd_idx_b  (rf_rd_idx_b),
        .rf_wr_en     (rf_wr_en),
        .rf_wr_idx    (rf_wr_idx),
        .rf_wr_data   (rf_wr_data),
        .hview        (hview),
        .wb_valid     (wb_valid),
        .wb_op        (wb_op),
        .wb_rd        (wb_rd),
        .wb_result    (wb_result),
        .wb_wr        (wb_wr),
        .wb_pc        (wb_pc)
    );

    pipe_tracker #(.PC_W(PC_W)) pipe_tracker_inst (
        .clk        (clk),
        .rst        (rst),
        .fetch_en   (fetch_en),
        .stall      (stall),
        .wb_valid   (wb_valid),
        .wb_op      (wb_op),
        .wb_rd      (wb_rd),
        .wb_result  (wb_result),
        .wb_wr      (wb_wr),
        .wb_pc      (wb_pc),
        .retire     (retire),
        .retire_rec (retire_rec)
    );

endmodule

// File: testbench/tb_toy_cpu.sv
// toy cpu testbench; one fixed program of 16 words, PC_W must stay 8 so the memory covers every pc
`timescale 1ns/1ps

module tb_toy_cpu import pipe_pkg::*; ();

    localparam int PC_W         = 8;
    localparam int PROG_LEN     = 16;
    localparam int RST_CYC      = 2;
    localparam int TAIL_CYC     = 10;
    localparam int WATCHDOG_CYC = PROG_LEN * 6 + 20;

    logic            clk;
    logic            rst;
    logic            start;
    instr_t          imem_data;
    logic [PC_W-1:0] imem_addr;
    logic            retire;
    retire_rec_t     retire_rec;
    logic            halted;

    // program memory and expected values per pc
    instr_t  prog       [2**PC_W];
    opcode_e exp_op     [2**PC_W];
    reg_idx_t exp_rd    [2**PC_W];
    word_t   exp_result [2**PC_W];
    logic    exp_wr     [2**PC_W];
    int      exp_stalls [2**PC_W];

    logic [16:0] lfsr_q = 17'd96989;
    logic        rst_d = 1'b0;
    int          since_halt = 0;
    int          n_ret = 0;
    int          mismatches = 0;
    int          failures = 0;

    toy_cpu_top #(.PC_W(PC_W)) toy_cpu_top_inst (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .imem_data  (imem_data),
        .imem_addr  (imem_addr),
        .retire     (retire),
        .retire_rec (retire_rec),
        .halted     (halted)
    );

    // memory answers in the same cycle
    assign imem_data = prog[imem_addr];

    initial clk = 1'b0;
    always #50 clk = ~clk;

    ////////////////////
    // stimulus helpers
    ////////////////////
    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsr_next(logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // one lfsr step per bit
    task automatic take_byte(output word_t b);
        b = '0;
        for (int k = 0; k < 8; k++) begin
            b      = {b[6:0], lfsr_q[16]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    task automatic place_instr(int idx, opcode_e op, reg_idx_t rd, reg_idx_t rs, word_t low);
        prog[PC_W'(idx)] = '{opcode: op, rd: rd, rs: rs, imm: low};
    endtask

    task automatic load_program();
        word_t imm;
        // unused words are nops whose immediate is their own address
        for (int a = 0; a < 2**PC_W; a++) begin
            prog[PC_W'(a)] = {8'h00, 8'(a)};
        end
        take_byte(imm);
        place_instr(0, op_addi, 2'd0, 2'd0, imm);
        take_byte(imm);
        place_instr(1, op_addi, 2'd1, 2'd1, imm);
        take_byte(imm);
        place_instr(2, op_addi, 2'd2, 2'd2, imm);
        // rt sits in the top two bits of the low byte
        place_instr(3, op_add, 2'd3, 2'd0, {2'd1, 6'd0});
        place_instr(4, op_sub, 2'd0, 2'd3, {2'd2, 6'd0});
        place_instr(5, op_nop, 2'd0, 2'd0, 8'd0);
        take_byte(imm);
        place_instr(6, op_addi, 2'd1, 2'd0, imm);
        place_instr(7, op_add, 2'd2, 2'd2, {2'd2, 6'd0});
        place_instr(8, op_sub, 2'd3, 2'd1, {2'd2, 6'd0});
        take_byte(imm);
        place_instr(9, op_addi, 2'd0, 2'd3, imm);
        take_byte(imm);
        place_instr(10, op_addi, 2'd1, 2'd2, imm);
        place_instr(11, op_sub, 2'd2, 2'd1, {2'd0, 6'd0});
        place_instr(12, op_add, 2'd3, 2'd3, {2'd3, 6'd0});
        place_instr(13, op_nop, 2'd0, 2'd0, 8'd0);
        place_instr(14, op_add, 2'd0, 2'd3, {2'd1, 6'd0});
        place_instr(15, op_halt, 2'd0, 2'd0, 8'd0);
    endtask

    ////////////////////
    // reference model
    ////////////////////
    // in-order run; leave is the relative cycle an instruction moves out of decode
    task automatic run_model();
        word_t           regs [4];
        int              dec_out [2**PC_W];
        logic [PC_W-1:0] ai;
        logic [PC_W-1:0] aj;
        instr_t          ins;
        opcode_e         op;
        reg_idx_t        rt;
        logic            uses_rs;
        logic            uses_rt;
        word_t           res;
        int              ready;
        int              leave;
        for (int r = 0; r < 4; r++) begin
            regs[r] = '0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            ai      = PC_W'(i);
            ins     = prog[ai];
            op      = opcode_e'(ins.opcode);
            rt      = ins.imm[7:6];
            uses_rs = op inside {op_add, op_sub, op_addi};
            uses_rt = op inside {op_add, op_sub};
            ready   = (i == 0) ? 0 : dec_out[PC_W'(i - 1)] + 1;
            leave   = ready;
            // a writer in execute or memory holds decode until it reaches write-back
            for (int j = 0; j < i; j++) begin
                aj = PC_W'(j);
                if (exp_wr[aj] && ((uses_rs && exp_rd[aj] == ins.rs) ||
                                   (uses_rt && exp_rd[aj] == rt))) begin
                    if (dec_out[aj] + 3 > leave) begin
                        leave = dec_out[aj] + 3;
                    end
                end
            end
            case (op)
                op_add:  res = regs[ins.rs] + regs[rt];
                op_sub:  res = regs[ins.rs] - regs[rt];
                op_addi: res = regs[ins.rs] + ins.imm;
                default: res = '0;
            endcase
            dec_out[ai]    = leave;
            exp_op[ai]     = op;
            exp_rd[ai]     = ins.rd;
            exp_wr[ai]     = uses_rs;
            exp_result[ai] = res;
            exp_stalls[ai] = leave - ready;
            if (uses_rs) begin
                regs[ins.rd] = res;
            end
        end
    endtask

    ////////////////////
    // checks
    ////////////////////
    task automatic expect_eq(string what, int got, int exp);
        assert (got == exp) else begin
            mismatches++;
            $display("mismatch at %0t: record %0d %s got %0d expected %0d",
                     $time, n_ret, what, got, exp);
        end
    endtask

    task automatic check_record(logic [PC_W-1:0] idx);
        expect_eq("tag", int'(retire_rec.tag), int'(idx));
        expect_eq("pc", int'(retire_rec.pc), int'(idx));
        expect_eq("opcode", int'(retire_rec.op), int'(exp_op[idx]));
        expect_eq("write flag", int'(retire_rec.wr), int'(exp_wr[idx]));
        if (exp_wr[idx]) begin
            expect_eq("rd", int'(retire_rec.rd), int'(exp_rd[idx]));
            expect_eq("result", int'(retire_rec.result), int'(exp_result[idx]));
        end
        expect_eq("stalls", int'(retire_rec.stalls), exp_stalls[idx]);
        // wb minus fetch is the pipe depth plus the hold cycles
        expect_eq("latency", int'(cyc_t'(retire_rec.wb_cyc - retire_rec.fetch_cyc)),
                  4 + exp_stalls[idx]);
    endtask

    task automatic report_counts();
        $display("retired %0d of %0d, mismatches %0d, other errors %0d",
                 n_ret, PROG_LEN, mismatches, failures);
    endtask

    // checks see the values from before each rising edge
    always @(posedge clk) begin
        rst_d <= rst;
        if (rst_d) begin
            assert (!retire && !halted) else begin
                mismatches++;
                $display("mismatch at %0t: retire or halted high in or right after reset", $time);
            end
        end
        if (since_halt > 0) begin
            assert (halted) else begin
                mismatches++;
                $display("mismatch at %0t: halted low %0d cycles after halt", $time, since_halt);
            end
            if (since_halt <= TAIL_CYC) begin
                assert (!retire) else begin
                    mismatches++;
                    $display("mismatch at %0t: retire after the halt retired", $time);
                end
            end
            since_halt++;
        end
        if (retire && !rst) begin
            if (n_ret >= PROG_LEN) begin
                failures++;
                $display("a retire came at %0t after the whole program had retired", $time);
            end else begin
                check_record(PC_W'(n_ret));
                if (retire_rec.op == op_halt) begin
                    since_halt = 1;
                end
            end
            n_ret++;
        end
    end

    // a halted core never retires
    halt_quiet: assert property (@(posedge clk) disable iff (rst) !(halted && retire))
        else begin
            mismatches++;
            $display("mismatch at %0t: retire while halted", $time);
        end

    ////////////////////
    // run
    ////////////////////
    initial begin
        rst   = 1'b1;
        start = 1'b0;
        load_program();
        run_model();
        repeat (RST_CYC) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!halted) @(negedge clk);
        repeat (TAIL_CYC) @(posedge clk);
        @(negedge clk);
        if (n_ret != PROG_LEN) begin
            failures++;
            $display("only %0d instructions retired, the program has %0d", n_ret, PROG_LEN);
        end
        report_counts();
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (RST_CYC + WATCHDOG_CYC + TAIL_CYC) @(posedge clk);
        failures++;
        $display("timeout: the core did not halt and settle within %0d cycles", WATCHDOG_CYC);
        report_counts();
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: src.f
common/pipe_pkg.sv
core/pipe_ctrl.sv
core/reg_file.sv
core/pipe_datapath.sv
trace/pipe_tracker.sv
hw/toy_cpu_top.sv
testbench/tb_toy_cpu.sv

// File: run_sim.sh
#!/bin/sh
# build the toy cpu testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_toy_cpu -o tb_toy_cpu
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_toy_cpu > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
    exit 1
fi
if ! grep -q "STATUS: PASS" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi
exit 0
